/* rtl/mem_geom_pkg.sv */
// ======================================================================
// Geometry of the tiled single-port RAM: 1024 words of 64 bits.
// The address space is split into NUM_BANKS equal banks, and the
// top address bits pick the bank. NUM_BANKS must be a power of two.
// ======================================================================
`default_nettype none

package mem_geom_pkg;

    // word and address geometry
    localparam int DATA_W    = 64;                         // bits per memory word
    localparam int ADDR_W    = 10;                         // full word address
    localparam int NUM_BANKS = 2;                          // address banks side by side
    localparam int BANK_AW   = ADDR_W - $clog2(NUM_BANKS); // address inside one bank

    // one memory word
    typedef logic [DATA_W-1:0] data_t;

    // per-bit write mask, 1 writes the bit
    typedef logic [DATA_W-1:0] mask_t;

    // full address as seen on the port
    typedef logic [ADDR_W-1:0] addr_t;

    // address presented to the macros of one bank
    typedef logic [BANK_AW-1:0] bank_addr_t;

endpackage : mem_geom_pkg

`default_nettype wire

/* rtl/mem_port_pkg.sv */
// ======================================================================
// Request bundle of the single-port RAM.
// Strobes only, with no handshake. ce=1 with we=1 writes and ce=1
// with we=0 reads. Any cycle with ce=0 is idle.
// ======================================================================
`default_nettype none

package mem_port_pkg;

    import mem_geom_pkg::*;

    // one port request, sampled on the rising clock edge
    typedef struct packed {
        logic  ce;    // chip enable
        logic  we;    // write enable, only meaningful with ce
        mask_t wmask; // per-bit write mask
        addr_t addr;  // word address across all banks
        data_t din;   // write data
    } mem_req_t;      // 140 bits

endpackage : mem_port_pkg

`default_nettype wire

/* rtl/rdata_merge.sv */
// ======================================================================
// Read-data combiner of the two banks.
// The bank of the last read is held in a register, so dout stays on
// that result while the other bank, or the same one, takes writes.
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module rdata_merge
    import mem_geom_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rd_strobe,   // ce and not we
    input  logic  rd_bank,     // top address bit of the request
    input  data_t bank0_rdata,
    input  data_t bank1_rdata,
    output data_t dout
);

    logic bank_q; // bank that served the last read

    // updates on the same edge as the macro output registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_q <= 1'b0;
        end else if (rd_strobe) begin
            bank_q <= rd_bank;
        end
    end

    // steer the owning bank to the port
    always_comb begin
        if (bank_q) begin
            dout = bank1_rdata;
        end else begin
            dout = bank0_rdata;
        end
    end

endmodule : rdata_merge

`default_nettype wire

/* rtl/sp_ram_tiled.sv */
// ======================================================================
// Tiled single-port RAM, 1024 x 64 with a per-bit write mask.
// Two banks of 512 words are built from MACRO_DW wide macros.
// Read latency is one cycle, and dout holds until the next read.
// dout is zero after reset until the first read completes.
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module sp_ram_tiled
    import mem_geom_pkg::*;
    import mem_port_pkg::*;
#(
    parameter int MACRO_DW = 32 // must divide DATA_W
) (
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t req,
    output data_t    dout
);

    data_t bank0_rdata;
    data_t bank1_rdata;
    logic  rd_strobe;

    assign rd_strobe = req.ce & ~req.we; // read request this cycle

    // lower half of the address space
    spram_bank #(
        .BANK_INDEX (0),
        .MACRO_DW   (MACRO_DW)
    ) u_bank0 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rdata (bank0_rdata)
    );

    // upper half of the address space
    spram_bank #(
        .BANK_INDEX (1),
        .MACRO_DW   (MACRO_DW)
    ) u_bank1 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rdata (bank1_rdata)
    );

    rdata_merge u_merge (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_strobe   (rd_strobe),
        .rd_bank     (req.addr[ADDR_W-1]), // bank select bit
        .bank0_rdata (bank0_rdata),
        .bank1_rdata (bank1_rdata),
        .dout        (dout)
    );

endmodule : sp_ram_tiled

`default_nettype wire

/* rtl/spram_bank.sv */
// ======================================================================
// One address bank of the tiled RAM.
// The bank answers only when the top address bit equals BANK_INDEX.
// The word is cut into DATA_W/MACRO_DW slices, one macro per slice,
// so MACRO_DW must divide DATA_W evenly.
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module spram_bank
    import mem_geom_pkg::*;
    import mem_port_pkg::*;
#(
    parameter int BANK_INDEX = 0,  // value of the top address bit served here
    parameter int MACRO_DW   = 32  // slice width of each macro
) (
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t req,
    output data_t    rdata  // joined macro outputs
);

    localparam int   NUM_MACROS = DATA_W / MACRO_DW;
    localparam logic BANK_BIT   = 1'(BANK_INDEX);

    logic       bank_sel;
    logic       bank_ce;
    logic       bank_we;
    bank_addr_t bank_addr;

    // bank decode from the top address bit
    assign bank_sel = (req.addr[ADDR_W-1] == BANK_BIT);

    // strobes reach the macros only for this bank
    assign bank_ce = req.ce & bank_sel;
    assign bank_we = req.we & bank_sel;

    // row address inside the bank
    assign bank_addr = req.addr[BANK_AW-1:0];

    // width tiling, slice g holds bits [g*MACRO_DW +: MACRO_DW]
    for (genvar g = 0; g < NUM_MACROS; g++) begin : g_slice
        logic [MACRO_DW-1:0] slice_wd;
        logic [MACRO_DW-1:0] slice_mask;
        logic [MACRO_DW-1:0] slice_rd;

        assign slice_wd   = req.din[g*MACRO_DW +: MACRO_DW];
        assign slice_mask = req.wmask[g*MACRO_DW +: MACRO_DW];

        sram_macro_model #(
            .MACRO_DW (MACRO_DW)
        ) u_macro (
            .clk       (clk),
            .rst_n     (rst_n),
            .ce_in     (bank_ce),
            .we_in     (bank_we),
            .addr_in   (bank_addr),
            .wd_in     (slice_wd),
            .w_mask_in (slice_mask),
            .rd_out    (slice_rd)
        );

        assign rdata[g*MACRO_DW +: MACRO_DW] = slice_rd; // rejoin the word
    end : g_slice

endmodule : spram_bank

`default_nettype wire

/* rtl/sram_macro_model.sv */
// ======================================================================
// Behavioral model of one single-port hard macro, 512 x MACRO_DW.
// The read data is registered and held until the next read. Only
// rd_out is cleared by rst_n, and the storage powers up unknown.
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module sram_macro_model
    import mem_geom_pkg::*;
#(
    parameter int MACRO_DW = 32 // slice width of the macro
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ce_in,     // macro enable
    input  logic                we_in,     // write when enabled
    input  bank_addr_t          addr_in,
    input  logic [MACRO_DW-1:0] wd_in,
    input  logic [MACRO_DW-1:0] w_mask_in, // 1 writes the bit
    output logic [MACRO_DW-1:0] rd_out
);

    localparam int DEPTH = 2 ** BANK_AW; // 512 rows

    logic [MACRO_DW-1:0] mem_q [DEPTH];
    logic                wr_en;
    logic                rd_en;

    assign wr_en = ce_in & we_in;
    assign rd_en = ce_in & ~we_in;

    // masked write. Unmasked bits keep the stored value
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[addr_in] <= (mem_q[addr_in] & ~w_mask_in) | (wd_in & w_mask_in);
        end
    end

    // output latch of the macro, loads only on a read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_out <= '0;
        end else if (rd_en) begin
            rd_out <= mem_q[addr_in]; // one cycle read
        end
    end

endmodule : sram_macro_model

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the tiled RAM testbench with Verilator.
# The exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

TOP=tb_sp_ram_tiled
OBJ_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

rm -rf "$OBJ_DIR"
rm -f "$LOG"

verilator --binary --timing \
    --timescale 1ns/1ps \
    --top-module "$TOP" \
    -Mdir "$OBJ_DIR" \
    -o "V$TOP" \
    -f src.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

if [ ! -x "$OBJ_DIR/V$TOP" ]; then
    echo "simulation binary $OBJ_DIR/V$TOP is missing"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" "$LOG"; then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL, see $LOG"
    exit 1
fi

/* src.f */
rtl/mem_geom_pkg.sv
rtl/mem_port_pkg.sv
rtl/sram_macro_model.sv
rtl/spram_bank.sv
rtl/rdata_merge.sv
rtl/sp_ram_tiled.sv
verif/tb_sp_ram_tiled.sv

/* verif/tb_sp_ram_tiled.sv */
// ======================================================================
// Directed testbench of the tiled 1024 x 64 RAM, MACRO_DW = 32.
// Inputs change on falling edges and dout is sampled there as well.
// Only bits that have been written are compared. Bits of a location
// that were never written are masked out of the check.
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_sp_ram_tiled
    import mem_geom_pkg::*;
    import mem_port_pkg::*;
();

    localparam int CLK_HALF      = 10; // 20 ns period
    localparam int RESET_TIMEOUT = 8;  // cycles to wait for rst_n release
    localparam int MIX_CYCLES    = 300;

    logic        clk = 1'b0;
    logic        rst_n;
    mem_req_t    req;
    data_t       dout;

    int unsigned err_cnt;
    int unsigned check_cnt;
    logic [31:0] lfsr_q;

    data_t       ref_mem [addr_t];   // reference contents
    mask_t       ref_known [addr_t]; // bits written so far
    data_t       last_exp;           // expected dout since the last read
    mask_t       last_known;

    sp_ram_tiled #(
        .MACRO_DW (32)
    ) uut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .dout  (dout)
    );

    always #CLK_HALF clk = ~clk;

    // reset held over two rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[62:0], fb};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input data_t actual, input data_t expected);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // masked write into the reference, bit by bit
    task automatic ref_write(input addr_t a, input data_t d, input mask_t m);
        data_t w;
        mask_t k;
        if (ref_mem.exists(a) != 0) begin
            w = ref_mem[a];
            k = ref_known[a];
        end else begin
            w = '0;
            k = '0;
        end
        for (int i = 0; i < DATA_W; i++) begin
            if (m[i]) begin
                w[i] = d[i]; // a set mask bit takes the new bit
                k[i] = 1'b1;
            end
        end
        ref_mem[a]   = w;
        ref_known[a] = k;
    endtask

    task automatic lookup_expected(input addr_t a, output data_t e, output mask_t k);
        if (ref_mem.exists(a) != 0) begin
            e = ref_mem[a];
            k = ref_known[a];
        end else begin
            e = '0;
            k = '0; // never written, nothing to compare
        end
    endtask

    // one request, held until the next falling edge
    task automatic drive_cycle(input logic ce, input logic we, input addr_t a,
                               input data_t d, input mask_t m);
        req.ce    = ce;
        req.we    = we;
        req.addr  = a;
        req.din   = d;
        req.wmask = m;
        if (ce && we) begin
            ref_write(a, d, m);
        end
        @(negedge clk);
    endtask

    task automatic check_dout();
        check_value("dout", dout & last_known, last_exp & last_known);
    endtask

    task automatic read_check(input addr_t a);
        data_t e;
        mask_t k;
        lookup_expected(a, e, k);
        drive_cycle(1'b1, 1'b0, a, '0, '0);
        last_exp   = e;
        last_known = k;
        check_dout(); // exactly one cycle after the request
    endtask

    task automatic test_reset();
        last_exp   = '0;
        last_known = '1;
        check_dout();
        repeat (2) begin
            drive_cycle(1'b0, 1'b0, '0, '0, '0);
            check_dout();
        end
    endtask

    task automatic test_full_writes();
        addr_t addrs [6];
        addrs = '{10'd0, 10'd100, 10'd511, 10'd512, 10'd700, 10'd1023};
        for (int i = 0; i < 6; i++) begin
            drive_cycle(1'b1, 1'b1, addrs[i], random_bits(64), '1);
            read_check(addrs[i]);
        end
    endtask

    task automatic test_masked_write();
        addr_t addrs [3];
        mask_t masks [3];
        addrs = '{10'd37, 10'd600, 10'd1000};
        masks = '{64'h0000_ffff_ffff_0000, 64'hf0f0_0000_0000_0f0f, 64'h8000_0001_8000_0001};
        for (int i = 0; i < 3; i++) begin
            drive_cycle(1'b1, 1'b1, addrs[i], random_bits(64), '1); // base word
            drive_cycle(1'b1, 1'b1, addrs[i], random_bits(64), masks[i]);
            read_check(addrs[i]);
        end
    endtask

    task automatic test_hold();
        drive_cycle(1'b1, 1'b1, 10'd200, random_bits(64), '1);
        read_check(10'd200);
        drive_cycle(1'b0, 1'b0, '0, '0, '0);
        check_dout();
        drive_cycle(1'b1, 1'b1, 10'd800, random_bits(64), '1); // other bank
        check_dout();
        drive_cycle(1'b1, 1'b1, 10'd200, random_bits(64), '1); // same address
        check_dout();
        drive_cycle(1'b0, 1'b0, '0, '0, '0);
        check_dout();
        read_check(10'd200); // new word only now
    endtask

    task automatic test_back_to_back();
        addr_t addrs [6];
        addrs = '{10'd5, 10'd517, 10'd6, 10'd518, 10'd5, 10'd518};
        for (int i = 0; i < 4; i++) begin
            drive_cycle(1'b1, 1'b1, addrs[i], random_bits(64), '1);
        end
        for (int i = 0; i < 6; i++) begin
            read_check(addrs[i]); // banks alternate every cycle
        end
    endtask

    task automatic test_random_mix();
        logic [63:0] r;
        addr_t       a;
        for (int i = 0; i < MIX_CYCLES; i++) begin
            r = random_bits(2);
            a = addr_t'(random_bits(10));
            a = {a[9], 5'b00000, a[3:0]}; // small window in each bank
            case (r[1:0])
                2'd0: begin
                    drive_cycle(1'b0, 1'b0, a, '0, '0);
                    check_dout();
                end
                2'd1: begin
                    drive_cycle(1'b1, 1'b1, a, random_bits(64), random_bits(64));
                    check_dout();
                end
                default: read_check(a);
            endcase
        end
    endtask

    initial begin
        int waited;
        req        = '0;
        lfsr_q     = 32'h9620394d;
        err_cnt    = 0;
        check_cnt  = 0;
        last_exp   = '0;
        last_known = '0;
        waited     = 0;
        while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            err_cnt++;
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
        end else begin
            test_reset();
            test_full_writes();
            test_masked_write();
            test_hold();
            test_back_to_back();
            test_random_mix();
        end
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_sp_ram_tiled

`default_nettype wire
